// ==== verilog/trap_cfg.svh ====
//////////////////////////////
// machine-mode trap settings, 64-bit only
// opcodes are internal codes, not ISA encodings
//////////////////////////////
`ifndef TRAP_CFG_SVH
`define TRAP_CFG_SVH

`define TRAP_XLEN          64
`define TRAP_CSR_ADDR_W    12
`define TRAP_OPCODE_W      8

// standard machine CSR addresses
`define TRAP_CSR_MSTATUS   12'h300
`define TRAP_CSR_MTVEC     12'h305
`define TRAP_CSR_MEPC      12'h341
`define TRAP_CSR_MCAUSE    12'h342

`define TRAP_OP_ECALL      8'h01
`define TRAP_OP_MRET       8'h02  // anything else with i_ena is a timer irq

`define TRAP_CAUSE_ECALL   64'd11
`define TRAP_CAUSE_MTIMER  64'h8000_0000_0000_0007

`define TRAP_MPP_M         2'b11
`define TRAP_MPP_U         2'b00
`define TRAP_CSR_RESET     {`TRAP_XLEN{1'b0}}

`endif

// ==== verilog/trap_pkg.sv ====
//////////////////////////////
// trap path types, field layout fixed to XLEN 64
//////////////////////////////
`default_nettype none

`include "trap_cfg.svh"

package trap_pkg;

  // one single-cycle CSR access
  typedef struct packed {
    logic [`TRAP_CSR_ADDR_W-1:0] addr;
    logic                        ren;
    logic                        wen;
    logic [`TRAP_XLEN-1:0]       wdata;
  } csr_req_t;

  typedef struct packed {
    logic                  valid;
    logic [`TRAP_XLEN-1:0] target;
  } pc_redirect_t;

  typedef struct packed {
    logic [`TRAP_XLEN-14:0] upper;
    logic [1:0]             mpp;    // 12:11
    logic [2:0]             rsv_10_8;
    logic                   mpie;   // 7
    logic [2:0]             rsv_6_4;
    logic                   mie;    // 3
    logic [2:0]             rsv_2_0;
  } mstatus_fields_t;

  typedef union packed {
    logic [`TRAP_XLEN-1:0] raw;
    mstatus_fields_t       f;
  } mstatus_u;

endpackage

`default_nettype wire

// ==== verilog/machine_csr_file.sv ====
//////////////////////////////
// mstatus/mtvec/mepc/mcause only, no privilege checks
// trap port write wins over sw port
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "trap_cfg.svh"

module machine_csr_file
  import trap_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  csr_req_t              i_trap_csr,
  output logic [`TRAP_XLEN-1:0] o_trap_rdata,
  input  csr_req_t              i_sw_csr,
  output logic [`TRAP_XLEN-1:0] o_sw_rdata
);

  mstatus_u              mstatus_q;
  logic [`TRAP_XLEN-1:0] mtvec_q;
  logic [`TRAP_XLEN-1:0] mepc_q;
  logic [`TRAP_XLEN-1:0] mcause_q;

  csr_req_t              wr;
  logic                  wr_en;

  function automatic logic [`TRAP_XLEN-1:0] csr_read(
    input logic [`TRAP_CSR_ADDR_W-1:0] addr
  );
    logic [`TRAP_XLEN-1:0] data;
    case (addr)
      `TRAP_CSR_MSTATUS: data = mstatus_q.raw;
      `TRAP_CSR_MTVEC:   data = mtvec_q;
      `TRAP_CSR_MEPC:    data = mepc_q;
      `TRAP_CSR_MCAUSE:  data = mcause_q;
      default:           data = '0;  // unmapped
    endcase
    return data;
  endfunction

  // reads are same-cycle on each port
  assign o_trap_rdata = i_trap_csr.ren ? csr_read(i_trap_csr.addr) : '0;
  assign o_sw_rdata   = i_sw_csr.ren   ? csr_read(i_sw_csr.addr)   : '0;

  always_comb begin
    wr    = i_trap_csr.wen ? i_trap_csr : i_sw_csr;
    wr_en = i_trap_csr.wen | i_sw_csr.wen;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q.raw <= `TRAP_CSR_RESET;
      mtvec_q       <= `TRAP_CSR_RESET;
      mepc_q        <= `TRAP_CSR_RESET;
      mcause_q      <= `TRAP_CSR_RESET;
    end else if (wr_en) begin
      case (wr.addr)
        `TRAP_CSR_MSTATUS: mstatus_q.raw <= wr.wdata;
        `TRAP_CSR_MTVEC:   mtvec_q       <= wr.wdata;
        `TRAP_CSR_MEPC:    mepc_q        <= wr.wdata;
        `TRAP_CSR_MCAUSE:  mcause_q      <= wr.wdata;
        default: ;  // dropped
      endcase
    end
  end

  a_trap_port_rw: assert property (@(posedge clk) disable iff (rst)
    !(i_trap_csr.ren && i_trap_csr.wen));

  a_sw_port_rw: assert property (@(posedge clk) disable iff (rst)
    !(i_sw_csr.ren && i_sw_csr.wen));

endmodule

`default_nettype wire

// ==== verilog/trap_sequencer.sv ====
//////////////////////////////
// runs trap entry / mret as fixed 3-cycle CSR accesses
// i_ena only seen while idle, stalls until i_ack
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "trap_cfg.svh"

module trap_sequencer
  import trap_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_ena,
  input  logic [`TRAP_OPCODE_W-1:0] i_inst_opcode,
  input  logic [`TRAP_XLEN-1:0]     i_pc,
  input  logic                      i_ack,
  output logic                      o_req,
  output pc_redirect_t              o_redirect,
  output csr_req_t                  o_csr,
  input  logic [`TRAP_XLEN-1:0]     i_csr_rdata
);

  localparam logic [3:0] S_IDLE         = 4'd0;
  // entry: ecall or timer
  localparam logic [3:0] S_ENT_MEPC     = 4'd1;
  localparam logic [3:0] S_ENT_MCAUSE   = 4'd2;
  localparam logic [3:0] S_ENT_MTVEC    = 4'd3;
  localparam logic [3:0] S_ENT_MSTAT_RD = 4'd4;
  localparam logic [3:0] S_ENT_MSTAT_WR = 4'd5;
  // return: mret
  localparam logic [3:0] S_RET_MSTAT_RD = 4'd6;
  localparam logic [3:0] S_RET_MEPC     = 4'd7;
  localparam logic [3:0] S_RET_MSTAT_WR = 4'd8;
  localparam logic [3:0] S_WAIT_ACK     = 4'd9;

  localparam logic [1:0] STEP_REQ = 2'd0;
  localparam logic [1:0] STEP_REL = 2'd1;

  logic [3:0]                  state;
  logic [1:0]                  step;
  logic                        req_q;

  logic [`TRAP_CSR_ADDR_W-1:0] csr_addr;
  logic                        csr_ren;
  logic                        csr_wen;
  logic [`TRAP_XLEN-1:0]       csr_wdata;

  // latched with i_ena, inputs last one cycle only
  logic [`TRAP_XLEN-1:0]       pc_q;
  logic [`TRAP_XLEN-1:0]       cause_q;
  mstatus_u                    mstatus_q;
  logic [`TRAP_XLEN-1:0]       target_q;  // mtvec on entry, mepc on return

  mstatus_u                    entry_mstatus;
  mstatus_u                    return_mstatus;

  // per-state access description
  logic [`TRAP_CSR_ADDR_W-1:0] acc_addr;
  logic                        acc_wr;
  logic [`TRAP_XLEN-1:0]       acc_wdata;
  logic [3:0]                  acc_next;

  always_comb begin
    entry_mstatus        = mstatus_q;
    entry_mstatus.f.mpp  = `TRAP_MPP_M;
    entry_mstatus.f.mpie = mstatus_q.f.mie;
    entry_mstatus.f.mie  = 1'b0;

    return_mstatus        = mstatus_q;
    return_mstatus.f.mpp  = `TRAP_MPP_U;
    return_mstatus.f.mie  = mstatus_q.f.mpie;
    return_mstatus.f.mpie = 1'b1;
  end

  always_comb begin
    acc_addr  = `TRAP_CSR_MSTATUS;
    acc_wr    = 1'b0;
    acc_wdata = '0;
    acc_next  = S_IDLE;
    case (state)
      S_ENT_MEPC: begin
        acc_addr  = `TRAP_CSR_MEPC;
        acc_wr    = 1'b1;
        acc_wdata = pc_q;
        acc_next  = S_ENT_MCAUSE;
      end
      S_ENT_MCAUSE: begin
        acc_addr  = `TRAP_CSR_MCAUSE;
        acc_wr    = 1'b1;
        acc_wdata = cause_q;
        acc_next  = S_ENT_MTVEC;
      end
      S_ENT_MTVEC: begin
        acc_addr = `TRAP_CSR_MTVEC;
        acc_next = S_ENT_MSTAT_RD;
      end
      S_ENT_MSTAT_RD: acc_next = S_ENT_MSTAT_WR;
      S_ENT_MSTAT_WR: begin
        acc_wr    = 1'b1;
        acc_wdata = entry_mstatus.raw;
        acc_next  = S_WAIT_ACK;
      end
      S_RET_MSTAT_RD: acc_next = S_RET_MEPC;
      S_RET_MEPC: begin
        acc_addr = `TRAP_CSR_MEPC;
        acc_next = S_RET_MSTAT_WR;
      end
      S_RET_MSTAT_WR: begin
        acc_wr    = 1'b1;
        acc_wdata = return_mstatus.raw;
        acc_next  = S_WAIT_ACK;
      end
      default: acc_next = S_IDLE;
    endcase
  end

  // control
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      step    <= STEP_REQ;
      req_q   <= 1'b0;
      csr_ren <= 1'b0;
      csr_wen <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_ena) begin
            state <= (i_inst_opcode == `TRAP_OP_MRET) ? S_RET_MSTAT_RD : S_ENT_MEPC;
            step  <= STEP_REQ;
          end
        end
        S_WAIT_ACK: begin
          if (i_ack) begin  // handshake done
            req_q <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: begin
          case (step)
            STEP_REQ: begin
              csr_ren <= ~acc_wr;
              csr_wen <= acc_wr;
              step    <= STEP_REL;
            end
            STEP_REL: begin
              csr_ren <= 1'b0;
              csr_wen <= 1'b0;
              step    <= 2'd2;
            end
            default: begin
              step  <= STEP_REQ;
              state <= acc_next;
              if (acc_next == S_WAIT_ACK) req_q <= 1'b1;
            end
          endcase
        end
      endcase
    end
  end

  // payload
  always_ff @(posedge clk) begin
    if (state == S_IDLE && i_ena) begin
      pc_q    <= i_pc;
      cause_q <= (i_inst_opcode == `TRAP_OP_ECALL) ? `TRAP_CAUSE_ECALL : `TRAP_CAUSE_MTIMER;
    end
    if (step == STEP_REQ) begin
      csr_addr  <= acc_addr;
      csr_wdata <= acc_wdata;
    end
    if (step == STEP_REL && csr_ren) begin
      if (csr_addr == `TRAP_CSR_MSTATUS) mstatus_q.raw <= i_csr_rdata;
      else                               target_q      <= i_csr_rdata;
    end
  end

  always_comb begin
    o_csr.addr  = csr_addr;
    o_csr.ren   = csr_ren;
    o_csr.wen   = csr_wen;
    o_csr.wdata = csr_wdata;
  end

  assign o_req             = req_q;
  assign o_redirect.valid  = req_q;
  assign o_redirect.target = target_q;

  a_no_rw_overlap: assert property (@(posedge clk) disable iff (rst)
    !(o_csr.ren && o_csr.wen));

  // request and jump target held until the pipeline takes them
  a_req_held: assert property (@(posedge clk) disable iff (rst)
    (o_req && !i_ack) |=> (o_req && $stable(o_redirect)));

endmodule

`default_nettype wire

// ==== verilog/trap_unit_top.sv ====
//////////////////////////////
// trap unit, sequencer plus machine CSRs
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "trap_cfg.svh"

module trap_unit_top
  import trap_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      i_ena,
  input  logic [`TRAP_OPCODE_W-1:0] i_inst_opcode,
  input  logic [`TRAP_XLEN-1:0]     i_pc,
  input  logic                      i_ack,
  output logic                      o_req,
  output pc_redirect_t              o_redirect,
  input  csr_req_t                  i_sw_csr,
  output logic [`TRAP_XLEN-1:0]     o_sw_rdata
);

  csr_req_t              trap_csr;
  logic [`TRAP_XLEN-1:0] trap_rdata;

  trap_sequencer u_seq (
    .clk           (clk),
    .rst           (rst),
    .i_ena         (i_ena),
    .i_inst_opcode (i_inst_opcode),
    .i_pc          (i_pc),
    .i_ack         (i_ack),
    .o_req         (o_req),
    .o_redirect    (o_redirect),
    .o_csr         (trap_csr),
    .i_csr_rdata   (trap_rdata)
  );

  machine_csr_file u_csr (
    .clk          (clk),
    .rst          (rst),
    .i_trap_csr   (trap_csr),
    .o_trap_rdata (trap_rdata),
    .i_sw_csr     (i_sw_csr),
    .o_sw_rdata   (o_sw_rdata)
  );

endmodule

`default_nettype wire

// ==== tests/trap_unit_tb.sv ====
//////////////////////////////
// table-driven trap unit test
// sw CSR accesses only while the sequencer is idle
//////////////////////////////
`timescale 1ns/100ps
`default_nettype none

`include "trap_cfg.svh"

module trap_unit_tb
  import trap_pkg::*;
();

  localparam int CLK_HALF      = 5;
  localparam int RST_CYCLES    = 10;
  localparam int MAX_ROWS      = 32;
  localparam int TRAP_WAIT_MAX = 32;
  localparam int WDOG_PER_ROW  = 40;

  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam logic [31:0] LFSR_SEED = 32'd24;

  localparam logic [1:0] K_WR     = 2'd0;
  localparam logic [1:0] K_RD     = 2'd1;
  localparam logic [1:0] K_TRAP   = 2'd2;
  localparam logic [1:0] K_ACKDLY = 2'd3;

  // where a data or expected value comes from
  localparam logic [1:0] SRC_TAB   = 2'd0;
  localparam logic [1:0] SRC_MTVEC = 2'd1;  // fresh random mtvec, or the last one
  localparam logic [1:0] SRC_PC    = 2'd2;
  localparam logic [1:0] SRC_RAND  = 2'd3;

  typedef struct packed {
    logic [1:0]                  kind;
    logic [`TRAP_CSR_ADDR_W-1:0] addr;  // csr address, opcode in low bits
    logic [1:0]                  dsrc;
    logic [`TRAP_XLEN-1:0]       data;
    logic [1:0]                  esrc;
    logic [`TRAP_XLEN-1:0]       exp_val;
  } row_t;

  logic                      clk = 1'b0;
  logic                      rst;
  logic                      i_ena;
  logic [`TRAP_OPCODE_W-1:0] i_inst_opcode;
  logic [`TRAP_XLEN-1:0]     i_pc;
  logic                      i_ack;
  logic                      o_req;
  pc_redirect_t              o_redirect;
  csr_req_t                  sw_req;
  logic [`TRAP_XLEN-1:0]     o_sw_rdata;

  row_t                      rows [MAX_ROWS];
  int                        n_rows;
  int                        n_checks;
  int                        n_errs;
  int                        row_errs;
  int                        ack_delay;
  logic                      table_ready = 1'b0;
  logic [31:0]               lfsr_q;
  logic [`TRAP_XLEN-1:0]     last_mtvec;
  logic [`TRAP_XLEN-1:0]     last_pc;

  trap_unit_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .i_ena         (i_ena),
    .i_inst_opcode (i_inst_opcode),
    .i_pc          (i_pc),
    .i_ack         (i_ack),
    .o_req         (o_req),
    .o_redirect    (o_redirect),
    .i_sw_csr      (sw_req),
    .o_sw_rdata    (o_sw_rdata)
  );

  always #CLK_HALF clk = ~clk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[62:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic string kind_name(input logic [1:0] k);
    case (k)
      K_WR:    return "sw write";
      K_RD:    return "sw read";
      K_TRAP:  return "trap";
      default: return "ack delay";
    endcase
  endfunction

  task automatic add_row(input logic [1:0] kind, input logic [11:0] addr,
                         input logic [1:0] dsrc, input logic [63:0] data,
                         input logic [1:0] esrc, input logic [63:0] exp_val);
    rows[n_rows] = '{kind, addr, dsrc, data, esrc, exp_val};
    n_rows++;
  endtask

  task automatic check(input string name, input logic [63:0] exp_v,
                       input logic [63:0] act);
    n_checks++;
    assert (act === exp_v) else begin
      $display("Mismatch %s: expected 0x%h, got 0x%h", name, exp_v, act);
      n_errs++;
      row_errs++;
    end
  endtask

  // one sw port cycle; read data sampled at the next falling edge
  task automatic sw_access(input logic [11:0] addr, input logic wr,
                           input logic [63:0] wdata, output logic [63:0] rdata);
    sw_req.addr  = addr;
    sw_req.ren   = ~wr;
    sw_req.wen   = wr;
    sw_req.wdata = wdata;
    @(negedge clk);
    rdata      = o_sw_rdata;
    sw_req.ren = 1'b0;
    sw_req.wen = 1'b0;
  endtask

  task automatic run_trap(input logic [7:0] opcode, input logic [63:0] pc,
                          input logic [63:0] exp_target);
    int           waited;
    pc_redirect_t held;
    i_ena         = 1'b1;
    i_inst_opcode = opcode;
    i_pc          = pc;
    @(negedge clk);
    i_ena  = 1'b0;
    waited = 0;
    while (!o_req && waited < TRAP_WAIT_MAX) begin
      @(negedge clk);
      waited++;
    end
    if (!o_req) begin
      $display("Error: o_req never rose within %0d cycles of the trap start", TRAP_WAIT_MAX);
      n_errs++;
      row_errs++;
    end else begin
      check("o_redirect.valid", 64'd1, 64'(o_redirect.valid));
      check("o_redirect.target", exp_target, o_redirect.target);
      held = o_redirect;
      for (int d = 0; d < ack_delay; d++) begin
        if (d == 0) begin
          i_ena         = 1'b1;  // stray timer strobe, must be dropped
          i_inst_opcode = 8'h07;
          i_pc          = '1;
        end
        @(negedge clk);
        i_ena = 1'b0;
        check("o_req", 64'd1, 64'(o_req));
        check("o_redirect", {63'd0, held.valid}, {63'd0, o_redirect.valid});
        check("o_redirect.target", held.target, o_redirect.target);
      end
      i_ack = 1'b1;
      @(negedge clk);
      i_ack = 1'b0;
      check("o_req", 64'd0, 64'(o_req));
      check("o_redirect.valid", 64'd0, 64'(o_redirect.valid));
    end
    ack_delay = 0;
  endtask

  task automatic run_row(input row_t r);
    logic [63:0] data;
    logic [63:0] exp_v;
    logic [63:0] rdata;
    case (r.dsrc)
      SRC_MTVEC: begin
        last_mtvec = rand_bits(64);
        data       = last_mtvec;
      end
      SRC_PC: begin
        last_pc = rand_bits(64);
        data    = last_pc;
      end
      default: data = r.data;
    endcase
    case (r.esrc)
      SRC_MTVEC: exp_v = last_mtvec;
      SRC_PC:    exp_v = last_pc;
      default:   exp_v = r.exp_val;
    endcase
    case (r.kind)
      K_WR: sw_access(r.addr, 1'b1, data, rdata);
      K_RD: begin
        sw_access(r.addr, 1'b0, '0, rdata);
        check("o_sw_rdata", exp_v, rdata);
      end
      K_TRAP:  run_trap(r.addr[7:0], data, exp_v);
      default: ack_delay = (r.dsrc == SRC_RAND) ? int'(rand_bits(3)) + 1 : int'(r.data);
    endcase
  endtask

  initial begin
    rst           = 1'b1;
    i_ena         = 1'b0;
    i_inst_opcode = '0;
    i_pc          = '0;
    i_ack         = 1'b0;
    sw_req        = '0;
    lfsr_q        = LFSR_SEED;
    last_mtvec    = '0;
    last_pc       = '0;
    n_rows        = 0;
    n_checks      = 0;
    n_errs        = 0;
    row_errs      = 0;
    ack_delay     = 0;

    // reset values
    add_row(K_RD,   `TRAP_CSR_MSTATUS, SRC_TAB,   '0, SRC_TAB,   '0);
    add_row(K_RD,   `TRAP_CSR_MTVEC,   SRC_TAB,   '0, SRC_TAB,   '0);
    add_row(K_RD,   `TRAP_CSR_MEPC,    SRC_TAB,   '0, SRC_TAB,   '0);
    add_row(K_RD,   `TRAP_CSR_MCAUSE,  SRC_TAB,   '0, SRC_TAB,   '0);
    // ecall entry, MIE=1 MPIE=0 going in
    add_row(K_WR,   `TRAP_CSR_MTVEC,   SRC_MTVEC, '0, SRC_TAB,   '0);
    add_row(K_WR,   `TRAP_CSR_MSTATUS, SRC_TAB, 64'hA5A5_0000_0000_0078, SRC_TAB, '0);
    add_row(K_TRAP, 12'(`TRAP_OP_ECALL), SRC_PC,  '0, SRC_MTVEC, '0);
    add_row(K_RD,   `TRAP_CSR_MEPC,    SRC_TAB,   '0, SRC_PC,    '0);
    add_row(K_RD,   `TRAP_CSR_MCAUSE,  SRC_TAB,   '0, SRC_TAB,   `TRAP_CAUSE_ECALL);
    add_row(K_RD,   `TRAP_CSR_MSTATUS, SRC_TAB,   '0, SRC_TAB,   64'hA5A5_0000_0000_18F0);
    // mret back to the saved pc
    add_row(K_TRAP, 12'(`TRAP_OP_MRET), SRC_TAB,  '0, SRC_PC,    '0);
    add_row(K_RD,   `TRAP_CSR_MSTATUS, SRC_TAB,   '0, SRC_TAB,   64'hA5A5_0000_0000_00F8);
    add_row(K_RD,   `TRAP_CSR_MEPC,    SRC_TAB,   '0, SRC_PC,    '0);
    // timer entry, MIE=0 MPIE=1 plus stray bits
    add_row(K_WR,   `TRAP_CSR_MTVEC,   SRC_MTVEC, '0, SRC_TAB,   '0);
    add_row(K_WR,   `TRAP_CSR_MSTATUS, SRC_TAB, 64'h0000_F000_0000_2084, SRC_TAB, '0);
    add_row(K_TRAP, 12'h007,           SRC_PC,    '0, SRC_MTVEC, '0);
    add_row(K_RD,   `TRAP_CSR_MEPC,    SRC_TAB,   '0, SRC_PC,    '0);
    add_row(K_RD,   `TRAP_CSR_MCAUSE,  SRC_TAB,   '0, SRC_TAB,   `TRAP_CAUSE_MTIMER);
    add_row(K_RD,   `TRAP_CSR_MSTATUS, SRC_TAB,   '0, SRC_TAB,   64'h0000_F000_0000_3804);
    // held ack, strobe during the wait is ignored
    add_row(K_ACKDLY, '0,              SRC_RAND,  '0, SRC_TAB,   '0);
    add_row(K_TRAP, 12'(`TRAP_OP_ECALL), SRC_PC,  '0, SRC_MTVEC, '0);
    add_row(K_RD,   `TRAP_CSR_MEPC,    SRC_TAB,   '0, SRC_PC,    '0);
    add_row(K_RD,   `TRAP_CSR_MCAUSE,  SRC_TAB,   '0, SRC_TAB,   `TRAP_CAUSE_ECALL);
    add_row(K_TRAP, 12'(`TRAP_OP_MRET), SRC_TAB,  '0, SRC_PC,    '0);
    add_row(K_RD,   `TRAP_CSR_MSTATUS, SRC_TAB,   '0, SRC_TAB,   64'h0000_F000_0000_2084);
    table_ready = 1'b1;

    repeat (RST_CYCLES) @(negedge clk);
    rst = 1'b0;
    check("o_req", 64'd0, 64'(o_req));
    check("o_redirect.valid", 64'd0, 64'(o_redirect.valid));
    $display("reset: %0d error(s)", row_errs);

    for (int i = 0; i < n_rows; i++) begin
      row_errs = 0;
      run_row(rows[i]);
      $display("row %0d %s: %s", i, kind_name(rows[i].kind), (row_errs == 0) ? "ok" : "failed");
    end

    $display("rows: %0d, checks: %0d, errors: %0d", n_rows, n_checks, n_errs);
    if (n_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (table_ready);
    repeat (RST_CYCLES + n_rows * WDOG_PER_ROW) @(posedge clk);
    $display("Timeout: tests still running after %0d cycles",
             RST_CYCLES + n_rows * WDOG_PER_ROW);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/trap_pkg.sv
verilog/machine_csr_file.sv
verilog/trap_sequencer.sv
verilog/trap_unit_top.sv
tests/trap_unit_tb.sv

// ==== Makefile ====
TOOL      = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = trap_unit_tb
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation FAILED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
